/* src/core_pkg.sv */
package core_pkg;

  localparam int XLEN      = 32;
  localparam int REG_ID_W  = 5;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [XLEN-1:0]     pc_t;
  typedef logic [31:0]         ins_t;
  typedef logic [REG_ID_W-1:0] reg_id_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_PASS_B   // lui and jal link
  } alu_op_e;

  typedef enum logic [1:0] {BR_NONE, BR_JAL, BR_BEQ, BR_BNE} br_kind_e;

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_HALT} ctrl_state_e;

  localparam pc_t BOOT_PC = 32'h0000_0000;

  // rv32i major opcodes
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  localparam ins_t INS_EBREAK = 32'h0010_0073;
  localparam ins_t NOP_INS    = 32'h0000_0013;  // addi x0,x0,0

endpackage

/* src/dec_bus_if.sv */
`timescale 1ns/1ps
interface dec_bus_if;

  logic                 valid;
  core_pkg::pc_t        pc;
  core_pkg::xlen_t      rs1_val;
  core_pkg::xlen_t      rs2_val;
  core_pkg::xlen_t      imm;
  core_pkg::alu_op_e    alu_op;
  logic                 b_is_imm;
  core_pkg::br_kind_e   br_kind;
  core_pkg::reg_id_t    rd_id;
  logic                 rd_wen;
  logic                 is_ebreak;

  modport out (output valid, pc, rs1_val, rs2_val, imm, alu_op, b_is_imm, br_kind,
               rd_id, rd_wen, is_ebreak);
  modport in  (input valid, pc, rs1_val, rs2_val, imm, alu_op, b_is_imm, br_kind,
               rd_id, rd_wen, is_ebreak);

endinterface

/* src/wb_bus_if.sv */
`timescale 1ns/1ps
interface wb_bus_if;

  logic               valid;
  core_pkg::pc_t      pc;
  core_pkg::reg_id_t  rd_id;
  logic               rd_wen;
  core_pkg::xlen_t    data;

  modport out (output valid, pc, rd_id, rd_wen, data);
  modport in  (input valid, pc, rd_id, rd_wen, data);

  // control only watches which instruction retires
  modport monitor (input valid, pc);

endinterface

/* src/ifu.sv */
`timescale 1ns/1ps
module ifu (
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic            i_fetch_en,
  input  logic            i_restart,
  input  logic            i_redirect,
  input  core_pkg::pc_t   i_target,
  input  logic            i_flush,
  output logic            o_imem_req,
  output core_pkg::pc_t   o_imem_addr,
  input  core_pkg::ins_t  i_imem_data,
  output logic            o_fd_valid,
  output core_pkg::pc_t   o_fd_pc,
  output core_pkg::ins_t  o_fd_ins
);

  core_pkg::pc_t pc;

  assign o_imem_req  = i_fetch_en;
  assign o_imem_addr = pc;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc         <= core_pkg::BOOT_PC;
      o_fd_valid <= 1'b0;
    end else begin
      if (i_restart) begin
        pc <= core_pkg::BOOT_PC;
      end else if (i_redirect) begin
        pc <= i_target;  // taken jump or branch from execute
      end else if (i_fetch_en) begin
        pc <= pc + 32'd4;
      end
      o_fd_valid <= i_fetch_en && !i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    o_fd_pc  <= pc;
    o_fd_ins <= i_imem_data;
  end

endmodule

/* src/idu.sv */
`timescale 1ns/1ps
module idu (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic               i_fd_valid,
  input  core_pkg::pc_t      i_fd_pc,
  input  core_pkg::ins_t     i_fd_ins,
  input  logic               i_flush,
  output core_pkg::reg_id_t  o_rs1_id,
  output core_pkg::reg_id_t  o_rs2_id,
  input  core_pkg::xlen_t    i_rs1_val,
  input  core_pkg::xlen_t    i_rs2_val,
  output logic               o_ebreak_seen,
  dec_bus_if.out             dec
);

  logic [6:0]          opc;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic                legal;
  logic                live;
  core_pkg::ins_t      ins;
  core_pkg::xlen_t     imm;
  core_pkg::alu_op_e   f3_op;
  core_pkg::alu_op_e   alu_op;
  logic                b_is_imm;
  core_pkg::br_kind_e  br_kind;
  logic                rd_wen;
  logic                is_ebreak;

  assign opc = i_fd_ins[6:0];
  assign f3  = i_fd_ins[14:12];
  assign f7  = i_fd_ins[31:25];

  always_comb begin
    case (opc)
      core_pkg::OPC_OP:     legal = (f7 == 7'b000_0000 && f3 != 3'b011) ||
                                    (f7 == 7'b010_0000 && f3 == 3'b000);
      core_pkg::OPC_OP_IMM: legal = (f3 == 3'b000 || f3 == 3'b100 || f3 == 3'b110 ||
                                     f3 == 3'b111) ||
                                    ((f3 == 3'b001 || f3 == 3'b101) && f7 == 7'b000_0000);
      core_pkg::OPC_LUI:    legal = 1'b1;
      core_pkg::OPC_JAL:    legal = 1'b1;
      core_pkg::OPC_BRANCH: legal = (f3 == 3'b000 || f3 == 3'b001);
      core_pkg::OPC_SYSTEM: legal = (i_fd_ins == core_pkg::INS_EBREAK);
      default:              legal = 1'b0;
    endcase
  end

  assign ins = legal ? i_fd_ins : core_pkg::NOP_INS;

  always_comb begin
    case (ins[14:12])
      3'b001:  f3_op = core_pkg::ALU_SLL;
      3'b010:  f3_op = core_pkg::ALU_SLT;
      3'b100:  f3_op = core_pkg::ALU_XOR;
      3'b101:  f3_op = core_pkg::ALU_SRL;
      3'b110:  f3_op = core_pkg::ALU_OR;
      3'b111:  f3_op = core_pkg::ALU_AND;
      default: f3_op = core_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    imm       = '0;
    alu_op    = core_pkg::ALU_ADD;
    b_is_imm  = 1'b0;
    br_kind   = core_pkg::BR_NONE;
    rd_wen    = 1'b0;
    is_ebreak = 1'b0;
    case (ins[6:0])
      core_pkg::OPC_OP: begin
        alu_op = (ins[14:12] == 3'b000 && ins[30]) ? core_pkg::ALU_SUB : f3_op;
        rd_wen = 1'b1;
      end
      core_pkg::OPC_OP_IMM: begin
        imm      = {{20{ins[31]}}, ins[31:20]};
        alu_op   = f3_op;
        b_is_imm = 1'b1;
        rd_wen   = 1'b1;
      end
      core_pkg::OPC_LUI: begin
        imm      = {ins[31:12], 12'b0};
        alu_op   = core_pkg::ALU_PASS_B;
        b_is_imm = 1'b1;
        rd_wen   = 1'b1;
      end
      core_pkg::OPC_JAL: begin
        imm     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        alu_op  = core_pkg::ALU_PASS_B;  // b becomes pc+4 in exu
        br_kind = core_pkg::BR_JAL;
        rd_wen  = 1'b1;
      end
      core_pkg::OPC_BRANCH: begin
        imm     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        br_kind = ins[12] ? core_pkg::BR_BNE : core_pkg::BR_BEQ;
      end
      default: begin
        is_ebreak = 1'b1;  // only ebreak survives the legal check here
      end
    endcase
  end

  assign o_rs1_id = ins[19:15];
  assign o_rs2_id = ins[24:20];

  // nothing behind an ebreak in execute may follow it
  assign live          = i_fd_valid && !i_flush && !(dec.valid && dec.is_ebreak);
  assign o_ebreak_seen = live && is_ebreak;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= live;
    end
  end

  always_ff @(posedge i_clk) begin
    dec.pc        <= i_fd_pc;
    dec.rs1_val   <= i_rs1_val;
    dec.rs2_val   <= i_rs2_val;
    dec.imm       <= imm;
    dec.alu_op    <= alu_op;
    dec.b_is_imm  <= b_is_imm;
    dec.br_kind   <= br_kind;
    dec.rd_id     <= rd_wen ? ins[11:7] : '0;
    dec.rd_wen    <= rd_wen;
    dec.is_ebreak <= is_ebreak;
  end

endmodule

/* src/exu.sv */
`timescale 1ns/1ps
module exu (
  input  logic               i_clk,
  input  logic               i_arst_n,
  dec_bus_if.in              dec,
  wb_bus_if.out              wb,
  output logic               o_fwd_valid,
  output logic               o_fwd_wen,
  output core_pkg::reg_id_t  o_fwd_rdid,
  output core_pkg::xlen_t    o_fwd_data,
  output logic               o_redirect,
  output core_pkg::pc_t      o_target
);

  core_pkg::xlen_t  op_a;
  core_pkg::xlen_t  op_b;
  core_pkg::xlen_t  alu_res;
  logic             rs_eq;

  assign op_a = dec.rs1_val;
  assign op_b = (dec.br_kind == core_pkg::BR_JAL) ? dec.pc + 32'd4 :  // link value
                dec.b_is_imm                      ? dec.imm : dec.rs2_val;

  always_comb begin
    case (dec.alu_op)
      core_pkg::ALU_SUB:    alu_res = op_a - op_b;
      core_pkg::ALU_AND:    alu_res = op_a & op_b;
      core_pkg::ALU_OR:     alu_res = op_a | op_b;
      core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
      core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
      core_pkg::ALU_SLT:    alu_res = core_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      core_pkg::ALU_PASS_B: alu_res = op_b;
      default:              alu_res = op_a + op_b;
    endcase
  end

  // branch resolution
  assign rs_eq      = (dec.rs1_val == dec.rs2_val);
  assign o_redirect = dec.valid && ((dec.br_kind == core_pkg::BR_JAL) ||
                                    (dec.br_kind == core_pkg::BR_BEQ && rs_eq) ||
                                    (dec.br_kind == core_pkg::BR_BNE && !rs_eq));
  assign o_target   = dec.pc + dec.imm;

  assign o_fwd_valid = dec.valid;
  assign o_fwd_wen   = dec.rd_wen;
  assign o_fwd_rdid  = dec.rd_id;
  assign o_fwd_data  = alu_res;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= dec.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    wb.pc     <= dec.pc;
    wb.rd_id  <= dec.rd_id;
    wb.rd_wen <= dec.rd_wen;
    wb.data   <= dec.rd_wen ? alu_res : '0;  // branches and ebreak retire zero
  end

endmodule

/* src/regfile_bypass.sv */
`timescale 1ns/1ps
module regfile_bypass (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  core_pkg::reg_id_t  i_rs1_id,
  input  core_pkg::reg_id_t  i_rs2_id,
  output core_pkg::xlen_t    o_rs1_val,
  output core_pkg::xlen_t    o_rs2_val,
  input  logic               i_fwd_valid,
  input  logic               i_fwd_wen,
  input  core_pkg::reg_id_t  i_fwd_rdid,
  input  core_pkg::xlen_t    i_fwd_data,
  wb_bus_if.in               wb
);

  core_pkg::xlen_t    regs [core_pkg::REG_COUNT];
  core_pkg::reg_id_t  rs_id [2];
  core_pkg::xlen_t    rs_val [2];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int r = 0; r < core_pkg::REG_COUNT; r++) begin
        regs[r] <= '0;
      end
    end else if (wb.valid && wb.rd_wen && wb.rd_id != '0) begin
      regs[wb.rd_id] <= wb.data;
    end
  end

  assign rs_id[0]  = i_rs1_id;
  assign rs_id[1]  = i_rs2_id;
  assign o_rs1_val = rs_val[0];
  assign o_rs2_val = rs_val[1];

  // youngest producer wins
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if (rs_id[p] == '0) begin
        rs_val[p] = '0;
      end else if (i_fwd_valid && i_fwd_wen && i_fwd_rdid == rs_id[p]) begin
        rs_val[p] = i_fwd_data;
      end else if (wb.valid && wb.rd_wen && wb.rd_id == rs_id[p]) begin
        rs_val[p] = wb.data;
      end else begin
        rs_val[p] = regs[rs_id[p]];
      end
    end
  end

endmodule

/* src/pipe_ctrl.sv */
`timescale 1ns/1ps
module pipe_ctrl (
  input  logic           i_clk,
  input  logic           i_arst_n,
  input  logic           i_start,
  input  logic           i_ebreak_seen,
  input  core_pkg::pc_t  i_ebreak_pc,
  input  logic           i_redirect,
  wb_bus_if.monitor      wb,
  output logic           o_fetch_en,
  output logic           o_restart,
  output logic           o_flush,
  output logic           o_halted
);

  core_pkg::ctrl_state_e  state;
  core_pkg::ctrl_state_e  state_nxt;
  core_pkg::pc_t          ebreak_pc;

  always_comb begin
    state_nxt = state;
    case (state)
      core_pkg::ST_IDLE,
      core_pkg::ST_HALT:  if (i_start) state_nxt = core_pkg::ST_RUN;
      core_pkg::ST_RUN:   if (i_ebreak_seen) state_nxt = core_pkg::ST_DRAIN;
      core_pkg::ST_DRAIN: if (wb.valid && wb.pc == ebreak_pc) state_nxt = core_pkg::ST_HALT;
      default:            state_nxt = core_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= core_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == core_pkg::ST_RUN && i_ebreak_seen) begin
      ebreak_pc <= i_ebreak_pc;  // drain ends when this pc retires
    end
  end

  assign o_restart  = i_start && (state == core_pkg::ST_IDLE || state == core_pkg::ST_HALT);
  assign o_fetch_en = (state == core_pkg::ST_RUN);
  assign o_flush    = i_redirect;
  assign o_halted   = (state == core_pkg::ST_HALT);

endmodule

/* src/core_top.sv */
`timescale 1ns/1ps
module core_top (
  input  logic               i_clk,
  input  logic               i_arst_n,
  output logic               o_imem_req,
  output core_pkg::pc_t      o_imem_addr,
  input  core_pkg::ins_t     i_imem_data,
  input  logic               i_start,
  output logic               o_halted,
  output logic               o_commit_valid,
  output core_pkg::pc_t      o_commit_pc,
  output core_pkg::reg_id_t  o_commit_rdid,
  output core_pkg::xlen_t    o_commit_data
);

  logic               fetch_en, restart, flush, redirect, ebreak_seen;
  core_pkg::pc_t      target, fd_pc;
  logic               fd_valid;
  core_pkg::ins_t     fd_ins;
  core_pkg::reg_id_t  rs1_id, rs2_id, fwd_rdid;
  core_pkg::xlen_t    rs1_val, rs2_val, fwd_data;
  logic               fwd_valid, fwd_wen;

  dec_bus_if dec_bus ();
  wb_bus_if  wb_bus ();

  ifu u_ifu (
    .i_clk       (i_clk),       .i_arst_n    (i_arst_n),
    .i_fetch_en  (fetch_en),    .i_restart   (restart),
    .i_redirect  (redirect),    .i_target    (target),
    .i_flush     (flush),       .o_imem_req  (o_imem_req),
    .o_imem_addr (o_imem_addr), .i_imem_data (i_imem_data),
    .o_fd_valid  (fd_valid),    .o_fd_pc     (fd_pc),
    .o_fd_ins    (fd_ins)
  );

  idu u_idu (
    .i_clk      (i_clk),    .i_arst_n      (i_arst_n),
    .i_fd_valid (fd_valid), .i_fd_pc       (fd_pc),
    .i_fd_ins   (fd_ins),   .i_flush       (flush),
    .o_rs1_id   (rs1_id),   .o_rs2_id      (rs2_id),
    .i_rs1_val  (rs1_val),  .i_rs2_val     (rs2_val),
    .dec        (dec_bus),  .o_ebreak_seen (ebreak_seen)
  );

  exu u_exu (
    .i_clk       (i_clk),     .i_arst_n   (i_arst_n),
    .dec         (dec_bus),   .wb         (wb_bus),
    .o_fwd_valid (fwd_valid), .o_fwd_wen  (fwd_wen),
    .o_fwd_rdid  (fwd_rdid),  .o_fwd_data (fwd_data),
    .o_redirect  (redirect),  .o_target   (target)
  );

  regfile_bypass u_regfile_bypass (
    .i_clk       (i_clk),     .i_arst_n   (i_arst_n),
    .i_rs1_id    (rs1_id),    .i_rs2_id   (rs2_id),
    .o_rs1_val   (rs1_val),   .o_rs2_val  (rs2_val),
    .i_fwd_valid (fwd_valid), .i_fwd_wen  (fwd_wen),
    .i_fwd_rdid  (fwd_rdid),  .i_fwd_data (fwd_data),
    .wb          (wb_bus)
  );

  pipe_ctrl u_pipe_ctrl (
    .i_clk         (i_clk),       .i_arst_n    (i_arst_n),
    .i_start       (i_start),     .i_redirect  (redirect),
    .i_ebreak_seen (ebreak_seen), .i_ebreak_pc (fd_pc),
    .wb            (wb_bus),      .o_fetch_en  (fetch_en),
    .o_restart     (restart),     .o_flush     (flush),
    .o_halted      (o_halted)
  );

  // retire port straight off writeback
  assign o_commit_valid = wb_bus.valid;
  assign o_commit_pc    = wb_bus.pc;
  assign o_commit_rdid  = wb_bus.rd_id;
  assign o_commit_data  = wb_bus.data;

endmodule

/* tests/core_top_properties.sv */
`timescale 1ns/1ps
module core_top_properties (
  input  logic           i_clk,
  input  logic           i_arst_n,
  input  logic           i_imem_req,
  input  logic           i_halted,
  input  logic           i_commit_valid,
  input  core_pkg::pc_t  i_commit_pc
);

  int fail_cnt = 0;

  a_no_commit_halted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_commit_valid && i_halted))
    else begin
      fail_cnt++;
      $error("commit while halted");
    end

  a_commit_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_commit_valid |-> (i_commit_pc[1:0] == 2'b00))
    else begin
      fail_cnt++;
      $error("misaligned commit pc %h", i_commit_pc);
    end

  // fetch already stopped while the pipe drained
  a_no_fetch_halted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_halted |-> (!i_imem_req && !$past(i_imem_req) && !$past(i_imem_req, 2)))
    else begin
      fail_cnt++;
      $error("fetch while halted or during the drain before it");
    end

endmodule

bind core_top core_top_properties u_props (
  .i_clk          (i_clk),
  .i_arst_n       (i_arst_n),
  .i_imem_req     (o_imem_req),
  .i_halted       (o_halted),
  .i_commit_valid (o_commit_valid),
  .i_commit_pc    (o_commit_pc)
);

/* tests/tb_core_top.sv */
`timescale 1ns/1ps
module tb_core_top;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 5;
  localparam int          STIM_DELAY   = 1;
  localparam int          MAX_CYCLES   = 2000;  // all programs plus margin
  localparam int          RAND_LEN     = 40;
  localparam int          HALT_WATCH   = 6;
  localparam logic [31:0] SEED         = 32'h0d12_975e;
  localparam logic [31:0] EBREAK       = 32'h0010_0073;

  logic                clk;
  logic                arst_n;
  logic                start;
  logic [31:0]         imem_data;
  logic                imem_req;
  core_pkg::pc_t       imem_addr;
  logic                halted;
  logic                commit_valid;
  core_pkg::pc_t       commit_pc;
  core_pkg::reg_id_t   commit_rdid;
  core_pkg::xlen_t     commit_data;

  logic [31:0] imem [256];
  int          prog_len = 0;
  logic [31:0] shadow [32];  // architectural state seen by the model
  logic [31:0] exp_pc [$];
  logic [31:0] exp_rd [$];
  logic [31:0] exp_data [$];
  bit          fetch_vld [MAX_CYCLES + 1];
  logic [31:0] fetch_addr [MAX_CYCLES + 1];
  int          cycle = 0;
  int          val_errs = 0;
  int          seq_errs = 0;
  int          prop_errs;

  core_top DUT (
    .i_clk          (clk),
    .i_arst_n       (arst_n),
    .o_imem_req     (imem_req),
    .o_imem_addr    (imem_addr),
    .i_imem_data    (imem_data),
    .i_start        (start),
    .o_halted       (halted),
    .o_commit_valid (commit_valid),
    .o_commit_pc    (commit_pc),
    .o_commit_rdid  (commit_rdid),
    .o_commit_data  (commit_data)
  );

  // asynchronous rom returning nop past the program
  assign imem_data = (imem_addr[31:2] < prog_len) ? imem[imem_addr[9:2]] : core_pkg::NOP_INS;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  always @(negedge clk) begin
    fetch_vld[cycle]  = imem_req;
    fetch_addr[cycle] = imem_addr;
  end

  initial begin
    wait (cycle >= MAX_CYCLES);
    $display("timeout: core did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input bit alt,
                                        input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, core_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, core_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_br(input bit bne, input logic [4:0] rs1, rs2,
                                         input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], core_pkg::OPC_BRANCH};
  endfunction

  // rv32i semantics of the funct3 groups
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                          input logic [31:0] a, b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic add_ins(input logic [31:0] ins);
    imem[prog_len] = ins;
    prog_len++;
  endtask

  task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      val_errs++;
      $display("[FAIL] %0t %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  // runs the program in order and queues the expected commits
  task automatic ref_model();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    bit          wen;
    bit          stop;
    int          steps;
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    pc    = core_pkg::BOOT_PC;
    stop  = 1'b0;
    steps = 0;
    while (!stop && steps < 500) begin
      ins = (pc[31:2] < prog_len) ? imem[pc[9:2]] : core_pkg::NOP_INS;
      a   = shadow[ins[19:15]];
      b   = shadow[ins[24:20]];
      nxt = pc + 32'd4;
      wen = 1'b0;
      res = '0;
      case (ins[6:0])
        core_pkg::OPC_OP: begin
          res = alu_ref(ins[14:12], ins[30], a, b);
          wen = 1'b1;
        end
        core_pkg::OPC_OP_IMM: begin
          res = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
          wen = 1'b1;
        end
        core_pkg::OPC_LUI: begin
          res = {ins[31:12], 12'h000};
          wen = 1'b1;
        end
        core_pkg::OPC_JAL: begin
          res = pc + 32'd4;
          wen = 1'b1;
          nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        core_pkg::OPC_BRANCH: begin
          if ((a == b) ^ ins[12]) nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        default: stop = (ins == EBREAK);
      endcase
      exp_pc.push_back(pc);
      exp_rd.push_back(wen ? {27'b0, ins[11:7]} : 32'h0);
      exp_data.push_back(res);
      if (wen && ins[11:7] != 5'd0) shadow[ins[11:7]] = res;
      pc = nxt;
      steps++;
    end
  endtask

  task automatic run_program(input string name);
    logic [31:0] e_pc;
    logic [31:0] e_rd;
    logic [31:0] e_data;
    int          last_cyc;
    bit          done;
    ref_model();
    @(posedge clk);
    #STIM_DELAY start = 1'b1;
    @(posedge clk);
    #STIM_DELAY start = 1'b0;
    @(negedge clk);
    assert (imem_req === 1'b1 && imem_addr === core_pkg::BOOT_PC) else begin
      seq_errs++;
      $display("%s: no fetch of the boot address one cycle after start", name);
    end
    done     = 1'b0;
    last_cyc = 0;
    while (!done) begin
      if (commit_valid) begin
        assert (exp_pc.size() > 0) else begin
          seq_errs++;
          $display("%s: commit of pc %h that the program never reaches", name, commit_pc);
        end
        if (exp_pc.size() > 0) begin
          e_pc   = exp_pc.pop_front();
          e_rd   = exp_rd.pop_front();
          e_data = exp_data.pop_front();
          check_val("o_commit_pc", commit_pc, e_pc);
          check_val("o_commit_rdid", {27'b0, commit_rdid}, e_rd);
          check_val("o_commit_data", commit_data, e_data);
        end
        assert (fetch_vld[cycle - 3] && fetch_addr[cycle - 3] === commit_pc) else begin
          seq_errs++;
          $display("%s: commit of pc %h was not fetched three cycles before", name, commit_pc);
        end
        last_cyc = cycle;
      end
      if (halted) begin
        assert (last_cyc != 0 && cycle == last_cyc + 1) else begin
          seq_errs++;
          $display("%s: halt did not follow the last commit by one cycle", name);
        end
        done = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    assert (exp_pc.size() == 0) else begin
      seq_errs++;
      $display("%s: core halted with %0d commits missing", name, exp_pc.size());
    end
    repeat (HALT_WATCH) begin
      @(negedge clk);
      assert (!commit_valid && !imem_req && halted) else begin
        seq_errs++;
        $display("%s: commit or fetch seen while halted", name);
      end
    end
  endtask

  task automatic check_idle_after_reset();
    repeat (8) begin
      @(negedge clk);
      assert (!imem_req && !commit_valid && !halted) else begin
        seq_errs++;
        $display("core active after reset before any start");
      end
    end
  endtask

  task automatic test_alu_chain();
    prog_len = 0;
    add_ins(enc_lui(5'd1, 20'h12345));
    add_ins(enc_i(3'b000, 5'd1, 5'd1, 12'h678));
    add_ins(enc_r(3'b000, 1'b0, 5'd2, 5'd1, 5'd1));
    add_ins(enc_r(3'b000, 1'b1, 5'd3, 5'd2, 5'd1));
    add_ins(enc_r(3'b100, 1'b0, 5'd4, 5'd3, 5'd2));
    add_ins(enc_r(3'b110, 1'b0, 5'd5, 5'd4, 5'd1));
    add_ins(enc_r(3'b111, 1'b0, 5'd6, 5'd5, 5'd3));
    add_ins(enc_i(3'b001, 5'd7, 5'd6, 12'd3));
    add_ins(enc_i(3'b101, 5'd8, 5'd7, 12'd5));
    add_ins(enc_r(3'b001, 1'b0, 5'd9, 5'd8, 5'd3));
    add_ins(enc_r(3'b101, 1'b0, 5'd10, 5'd9, 5'd4));
    add_ins(enc_r(3'b010, 1'b0, 5'd11, 5'd10, 5'd9));
    add_ins(enc_i(3'b000, 5'd12, 5'd11, 12'h800));  // -2048
    add_ins(enc_r(3'b010, 1'b0, 5'd13, 5'd12, 5'd1));
    add_ins(enc_i(3'b100, 5'd14, 5'd13, 12'hfa5));
    add_ins(enc_i(3'b110, 5'd15, 5'd14, 12'h0f0));
    add_ins(enc_i(3'b111, 5'd16, 5'd15, 12'h3c3));
    add_ins(EBREAK);
    run_program("alu chain");
  endtask

  task automatic test_x0_writes();
    prog_len = 0;
    add_ins(enc_i(3'b000, 5'd1, 5'd0, 12'd7));
    add_ins(enc_i(3'b000, 5'd0, 5'd1, 12'd100));    // commits 107 while x0 stays zero
    add_ins(enc_r(3'b000, 1'b0, 5'd2, 5'd0, 5'd1));
    add_ins(enc_r(3'b110, 1'b0, 5'd0, 5'd2, 5'd1));
    add_ins(enc_i(3'b000, 5'd3, 5'd0, 12'd5));
    add_ins(EBREAK);
    run_program("x0 writes");
  endtask

  task automatic test_branches();
    prog_len = 0;
    add_ins(enc_i(3'b000, 5'd1, 5'd0, 12'd5));      // 0x00
    add_ins(enc_i(3'b000, 5'd2, 5'd0, 12'd5));
    add_ins(enc_jal(5'd3, 21'd12));                 // 0x08 to 0x14
    add_ins(enc_i(3'b000, 5'd4, 5'd0, 12'd1));
    add_ins(enc_i(3'b000, 5'd4, 5'd0, 12'd2));
    add_ins(enc_br(1'b0, 5'd1, 5'd2, 13'd12));      // 0x14 beq taken
    add_ins(enc_i(3'b000, 5'd5, 5'd0, 12'd1));
    add_ins(enc_i(3'b000, 5'd5, 5'd0, 12'd2));
    add_ins(enc_br(1'b1, 5'd1, 5'd2, 13'd8));       // 0x20 bne not taken
    add_ins(enc_br(1'b0, 5'd1, 5'd0, 13'd8));       // beq not taken
    add_ins(enc_br(1'b1, 5'd1, 5'd0, 13'd12));      // 0x28 bne taken
    add_ins(enc_i(3'b000, 5'd6, 5'd0, 12'd1));
    add_ins(enc_i(3'b000, 5'd6, 5'd0, 12'd2));
    add_ins(enc_r(3'b000, 1'b0, 5'd7, 5'd3, 5'd0)); // 0x34 link value
    add_ins(enc_jal(5'd0, 21'd8));
    add_ins(enc_i(3'b000, 5'd8, 5'd0, 12'd9));
    add_ins(enc_i(3'b000, 5'd9, 5'd0, 12'd3));      // 0x40 small countdown loop
    add_ins(enc_i(3'b000, 5'd9, 5'd9, 12'hfff));
    add_ins(enc_br(1'b1, 5'd9, 5'd0, -13'sd4));
    add_ins(EBREAK);
    run_program("branches");
  endtask

  task automatic test_random_halt();
    logic [2:0] r_f3 [7];
    logic [2:0] i_f3 [6];
    logic [2:0] f3;
    logic [11:0] imm;
    r_f3 = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b110, 3'b111};
    i_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    prog_len = 0;
    // few registers so that most operands hit the bypass
    for (int i = 0; i < RAND_LEN; i++) begin
      case ($urandom % 3)
        0: begin
          f3 = r_f3[$urandom % 7];
          add_ins(enc_r(f3, (f3 == 3'b000) && ($urandom % 2 == 1),
                        $urandom % 8, $urandom % 8, $urandom % 8));
        end
        1: begin
          f3  = i_f3[$urandom % 6];
          imm = $urandom;
          if (f3 == 3'b001 || f3 == 3'b101) imm = {7'b0, imm[4:0]};
          add_ins(enc_i(f3, $urandom % 8, $urandom % 8, imm));
        end
        default: add_ins(enc_lui($urandom % 8, $urandom));
      endcase
    end
    add_ins(EBREAK);
    run_program("random");
    run_program("random restart");
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n   = 1'b0;
    start    = 1'b0;
    for (int r = 0; r < 32; r++) shadow[r] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #STIM_DELAY arst_n = 1'b1;
    check_idle_after_reset();
    test_alu_chain();
    test_x0_writes();
    test_branches();
    test_random_halt();
    prop_errs = DUT.u_props.fail_cnt;
    $display("errors: %0d value, %0d sequence, %0d property", val_errs, seq_errs, prop_errs);
    if (val_errs + seq_errs + prop_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
src/core_pkg.sv
src/dec_bus_if.sv
src/wb_bus_if.sv
src/ifu.sv
src/idu.sv
src/exu.sv
src/regfile_bypass.sv
src/pipe_ctrl.sv
src/core_top.sv
tests/core_top_properties.sv
tests/tb_core_top.sv

/* Bender.yml */
package:
  name: core_top

sources:
  - src/core_pkg.sv
  - src/dec_bus_if.sv
  - src/wb_bus_if.sv
  - src/ifu.sv
  - src/idu.sv
  - src/exu.sv
  - src/regfile_bypass.sv
  - src/pipe_ctrl.sv
  - src/core_top.sv
  - target: test
    files:
      - tests/core_top_properties.sv
      - tests/tb_core_top.sv
